/* logic/hbm_pkg.sv */
`default_nettype none

package hbm_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////

    localparam int HBM_DATA_W  = 256;             // one hbm read beat
    localparam int DISPATCH_W  = 2 * HBM_DATA_W;  // lo + hi beat of an engine pair
    localparam int HBM_ADDR_W  = 33;              // 8G byte space per port
    localparam int BURST_BEATS = 4;               // beats per read burst
    localparam int BURST_CNT_W = 16;              // burst-count setting

    typedef logic [HBM_ADDR_W-1:0] hbm_addr_t;

    ////////////////////////////////////////////////////////////
    // bus payloads
    ////////////////////////////////////////////////////////////

    // read-address request, 41 bits
    typedef struct packed {
        hbm_addr_t  addr;  // byte address of burst start
        logic [7:0] len;   // beats minus one
    } ar_cmd_t;

    // read-data beat, 257 bits
    typedef struct packed {
        logic [HBM_DATA_W-1:0] data;
        logic                  last;  // final beat of burst
    } rd_beat_t;

    // run sequence of the read side
    typedef enum logic [1:0] {
        RUN_IDLE  = 2'd0,  // waiting for start
        RUN_ISSUE = 2'd1,  // channels sending read requests
        RUN_DRAIN = 2'd2,  // waiting for beats and fifos
        RUN_DONE  = 2'd3   // one cycle, done pulse
    } run_state_e;

endpackage

`default_nettype wire

/* logic/hbm_run_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module hbm_run_ctrl (
    input  wire                  hbm_clk,
    input  wire                  hbm_rstn,

    input  wire                  start_i,        // one-cycle pulse
    input  wire                  issue_done_i,   // and of all channels
    input  wire                  rx_done_i,      // and of all channels
    input  wire                  fifos_empty_i,  // and of all channel fifos

    output hbm_pkg::run_state_e  state_o,
    output logic                 done_o
);

    import hbm_pkg::*;

    run_state_e state_d;

    ////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_o;  // hold by default
        case (state_o)
            RUN_IDLE: begin
                if (start_i) begin  // start ignored elsewhere
                    state_d = RUN_ISSUE;
                end
            end
            RUN_ISSUE: begin
                if (issue_done_i) begin  // every channel sent its bursts
                    state_d = RUN_DRAIN;
                end
            end
            RUN_DRAIN: begin
                // all beats in and every fifo popped out
                if (rx_done_i && fifos_empty_i) begin
                    state_d = RUN_DONE;
                end
            end
            RUN_DONE: state_d = RUN_IDLE;  // single cycle
            default:  state_d = RUN_IDLE;
        endcase
    end

    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            state_o <= RUN_IDLE;
        end else begin
            state_o <= state_d;
        end
    end

    assign done_o = (state_o == RUN_DONE);  // pulse, one cycle in done

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    // a run only begins from a start seen in idle
    a_start_only: assert property (@(posedge hbm_clk) disable iff (!hbm_rstn)
        (state_o != RUN_IDLE) && ($past(state_o) == RUN_IDLE) |-> $past(start_i));

endmodule

`default_nettype wire

/* logic/hbm_burst_counter.sv */
`timescale 1ns/10ps
`default_nettype none

module hbm_burst_counter (
    input  wire                              hbm_clk,
    input  wire                              hbm_rstn,

    input  wire hbm_pkg::run_state_e         state_i,
    input  wire hbm_pkg::hbm_addr_t          base_addr_i,
    input  wire hbm_pkg::hbm_addr_t          stride_i,
    input  wire [hbm_pkg::BURST_CNT_W-1:0]   burst_count_i,

    output logic                             ar_valid_o,
    output hbm_pkg::ar_cmd_t                 ar_o,
    input  wire                              ar_ready_i,

    input  wire                              beat_accept_i,  // r valid and ready
    output logic                             issue_done_o,
    output logic                             rx_done_o
);

    import hbm_pkg::*;

    localparam int         BEAT_CNT_W = BURST_CNT_W + $clog2(BURST_BEATS);
    localparam logic [7:0] AR_LEN     = 8'(BURST_BEATS - 1);

    logic                   armed_q;        // settings taken for this run
    hbm_addr_t              addr_q;
    hbm_addr_t              stride_q;
    logic [BURST_CNT_W-1:0] burst_total_q;
    logic [BURST_CNT_W-1:0] burst_cnt_q;    // accepted requests
    logic [BEAT_CNT_W-1:0]  beat_total_q;
    logic [BEAT_CNT_W-1:0]  beat_cnt_q;     // accepted beats
    logic                   ar_fire;
    logic                   arm;

    assign ar_fire = ar_valid_o & ar_ready_i;
    assign arm     = (state_i == RUN_ISSUE) && !armed_q;  // first issue cycle

    ////////////////////////////////////////////////////////////
    // request and beat counting
    ////////////////////////////////////////////////////////////

    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn || state_i == RUN_IDLE) begin
            armed_q      <= 1'b0;
            ar_valid_o   <= 1'b0;
            issue_done_o <= 1'b0;
            rx_done_o    <= 1'b0;
            burst_cnt_q  <= '0;
            beat_cnt_q   <= '0;
        end else if (arm) begin
            armed_q      <= 1'b1;
            ar_valid_o   <= (burst_count_i != '0);
            issue_done_o <= (burst_count_i == '0);  // zero count, nothing to do
            rx_done_o    <= (burst_count_i == '0);
        end else begin
            if (ar_fire) begin
                burst_cnt_q <= burst_cnt_q + 1'b1;
                if (burst_cnt_q + 1'b1 == burst_total_q) begin  // last request taken
                    ar_valid_o   <= 1'b0;
                    issue_done_o <= 1'b1;
                end
            end
            if (beat_accept_i && !rx_done_o) begin
                beat_cnt_q <= beat_cnt_q + 1'b1;
                if (beat_cnt_q + 1'b1 == beat_total_q) begin
                    rx_done_o <= 1'b1;
                end
            end
        end
    end

    // settings and address walk
    always_ff @(posedge hbm_clk) begin
        if (arm) begin
            addr_q        <= base_addr_i;
            stride_q      <= stride_i;
            burst_total_q <= burst_count_i;
            beat_total_q  <= BEAT_CNT_W'(burst_count_i) * BEAT_CNT_W'(BURST_BEATS);
        end else if (ar_fire) begin
            addr_q <= addr_q + stride_q;  // next burst one stride on
        end
    end

    assign ar_o.addr = addr_q;
    assign ar_o.len  = AR_LEN;

    // request stays put while the memory stalls it
    a_ar_hold: assert property (@(posedge hbm_clk) disable iff (!hbm_rstn)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o));

    // memory sends no more beats than were requested
    a_no_extra_beat: assert property (@(posedge hbm_clk) disable iff (!hbm_rstn)
        rx_done_o |-> !beat_accept_i);

endmodule

`default_nettype wire

/* logic/hbm_chan_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module hbm_chan_fifo #(
    parameter int FIFO_DEPTH = 16,
    parameter int PROG_FULL  = 12
) (
    input  wire                              hbm_clk,
    input  wire                              hbm_rstn,

    input  wire                              push_i,
    input  wire [hbm_pkg::HBM_DATA_W-1:0]    din_i,
    input  wire                              pop_i,
    output logic [hbm_pkg::HBM_DATA_W-1:0]   dout_o,   // head, read without latency

    output logic                             empty_o,
    output logic                             prog_full_o
);

    import hbm_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [HBM_DATA_W-1:0] mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0]      wr_ptr_q;
    logic [PTR_W-1:0]      rd_ptr_q;
    logic [CNT_W-1:0]      count_q;   // occupancy

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge hbm_clk) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= din_i;
        end
    end

    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin  // wrap at depth, need not be power of two
                wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;  // both or neither
            endcase
        end
    end

    assign dout_o      = mem_q[rd_ptr_q];
    assign empty_o     = (count_q == '0);
    assign prog_full_o = (count_q >= CNT_W'(PROG_FULL));  // drops r_ready upstream

    // upstream ready must stop pushes before the buffer overflows
    a_no_overflow: assert property (@(posedge hbm_clk) disable iff (!hbm_rstn)
        push_i && !pop_i |-> count_q < CNT_W'(FIFO_DEPTH));

    // lane pair only pops a fifo holding data
    a_no_underflow: assert property (@(posedge hbm_clk) disable iff (!hbm_rstn)
        pop_i |-> !empty_o);

endmodule

`default_nettype wire

/* logic/hbm_lane_pair.sv */
`timescale 1ns/10ps
`default_nettype none

module hbm_lane_pair (
    input  wire                              hbm_clk,
    input  wire                              hbm_rstn,

    input  wire [hbm_pkg::HBM_DATA_W-1:0]    lo_data_i,   // even channel head
    input  wire [hbm_pkg::HBM_DATA_W-1:0]    hi_data_i,   // odd channel head
    input  wire                              lo_empty_i,
    input  wire                              hi_empty_i,
    input  wire                              almost_full_i,

    output logic                             pop_o,       // pops both fifos
    output logic [hbm_pkg::DISPATCH_W-1:0]   dispatch_data_o,
    output logic                             dispatch_wr_en_o
);

    logic af_q;  // registered almost-full from the engine

    ////////////////////////////////////////////////////////////
    // pop decision
    ////////////////////////////////////////////////////////////

    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            af_q <= 1'b0;
        end else begin
            af_q <= almost_full_i;
        end
    end

    // both halves present and engine has room
    assign pop_o = !lo_empty_i && !hi_empty_i && !af_q;

    ////////////////////////////////////////////////////////////
    // dispatch word
    ////////////////////////////////////////////////////////////

    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            dispatch_wr_en_o <= 1'b0;
        end else begin
            dispatch_wr_en_o <= pop_o;  // one cycle after the pop
        end
    end

    always_ff @(posedge hbm_clk) begin
        if (pop_o) begin
            dispatch_data_o <= {hi_data_i, lo_data_i};  // odd channel on top
        end
    end

endmodule

`default_nettype wire

/* logic/hbm_read_top.sv */
`timescale 1ns/10ps
`default_nettype none

module hbm_read_top #(
    parameter int ENGINE_NUM = 2,   // two channels per engine
    parameter int FIFO_DEPTH = 16,
    parameter int PROG_FULL  = 12
) (
    input  wire                                                hbm_clk,
    input  wire                                                hbm_rstn,

    input  wire                                                start_i,
    input  wire hbm_pkg::hbm_addr_t                            base_addr_i,
    input  wire hbm_pkg::hbm_addr_t                            stride_i,
    input  wire [hbm_pkg::BURST_CNT_W-1:0]                     burst_count_i,

    // read address, one port per channel
    output wire [2*ENGINE_NUM-1:0]                             ar_valid_o,
    output wire hbm_pkg::ar_cmd_t [2*ENGINE_NUM-1:0]           ar_o,
    input  wire [2*ENGINE_NUM-1:0]                             ar_ready_i,

    // read data
    input  wire [2*ENGINE_NUM-1:0]                             r_valid_i,
    input  wire hbm_pkg::rd_beat_t [2*ENGINE_NUM-1:0]          r_i,
    output wire [2*ENGINE_NUM-1:0]                             r_ready_o,

    // engine side, write strobe with no ready
    output wire [ENGINE_NUM-1:0][hbm_pkg::DISPATCH_W-1:0]      dispatch_data_o,
    output wire [ENGINE_NUM-1:0]                               dispatch_wr_en_o,
    input  wire [ENGINE_NUM-1:0]                               dispatch_almost_full_i,

    output wire                                                done_o
);

    import hbm_pkg::*;

    localparam int CHAN_NUM = 2 * ENGINE_NUM;

    run_state_e                          run_state;
    wire [CHAN_NUM-1:0]                  issue_done;
    wire [CHAN_NUM-1:0]                  rx_done;
    wire [CHAN_NUM-1:0]                  fifo_empty;
    wire [CHAN_NUM-1:0]                  fifo_pfull;
    wire [CHAN_NUM-1:0]                  beat_accept;   // r handshake per channel
    wire [CHAN_NUM-1:0][HBM_DATA_W-1:0]  fifo_dout;
    wire [ENGINE_NUM-1:0]                pair_pop;

    hbm_run_ctrl i_run_ctrl (
        .hbm_clk       (hbm_clk),
        .hbm_rstn      (hbm_rstn),
        .start_i       (start_i),
        .issue_done_i  (&issue_done),
        .rx_done_i     (&rx_done),
        .fifos_empty_i (&fifo_empty),
        .state_o       (run_state),
        .done_o        (done_o)
    );

    ////////////////////////////////////////////////////////////
    // per channel: address walk and beat buffer
    ////////////////////////////////////////////////////////////

    for (genvar c = 0; c < CHAN_NUM; c++) begin : g_chan
        assign r_ready_o[c]   = ~fifo_pfull[c];  // back-pressure from fifo level
        assign beat_accept[c] = r_valid_i[c] & r_ready_o[c];

        hbm_burst_counter i_burst_counter (
            .hbm_clk       (hbm_clk),
            .hbm_rstn      (hbm_rstn),
            .state_i       (run_state),
            .base_addr_i   (base_addr_i),
            .stride_i      (stride_i),
            .burst_count_i (burst_count_i),
            .ar_valid_o    (ar_valid_o[c]),
            .ar_o          (ar_o[c]),
            .ar_ready_i    (ar_ready_i[c]),
            .beat_accept_i (beat_accept[c]),
            .issue_done_o  (issue_done[c]),
            .rx_done_o     (rx_done[c])
        );

        hbm_chan_fifo #(
            .FIFO_DEPTH (FIFO_DEPTH),
            .PROG_FULL  (PROG_FULL)
        ) i_chan_fifo (
            .hbm_clk     (hbm_clk),
            .hbm_rstn    (hbm_rstn),
            .push_i      (beat_accept[c]),
            .din_i       (r_i[c].data),
            .pop_i       (pair_pop[c/2]),   // both of a pair pop together
            .dout_o      (fifo_dout[c]),
            .empty_o     (fifo_empty[c]),
            .prog_full_o (fifo_pfull[c])
        );
    end

    // per engine: join even and odd channel
    for (genvar e = 0; e < ENGINE_NUM; e++) begin : g_engine
        hbm_lane_pair i_lane_pair (
            .hbm_clk          (hbm_clk),
            .hbm_rstn         (hbm_rstn),
            .lo_data_i        (fifo_dout[2*e]),
            .hi_data_i        (fifo_dout[2*e+1]),
            .lo_empty_i       (fifo_empty[2*e]),
            .hi_empty_i       (fifo_empty[2*e+1]),
            .almost_full_i    (dispatch_almost_full_i[e]),
            .pop_o            (pair_pop[e]),
            .dispatch_data_o  (dispatch_data_o[e]),
            .dispatch_wr_en_o (dispatch_wr_en_o[e])
        );
    end

endmodule

`default_nettype wire

/* verification/tb_hbm_read.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_hbm_read;

    import hbm_pkg::*;

    localparam int ENGINE_NUM   = 2;
    localparam int CHAN_NUM     = 2 * ENGINE_NUM;
    localparam int RUN_TIMEOUT  = 4000;  // cycles per run
    localparam int QUIET_CYCLES = 20;

    logic                                  hbm_clk;
    logic                                  hbm_rstn;
    logic                                  start_i;
    hbm_addr_t                             base_addr_i;
    hbm_addr_t                             stride_i;
    logic [BURST_CNT_W-1:0]                burst_count_i;
    logic [CHAN_NUM-1:0]                   ar_valid_o;
    ar_cmd_t [CHAN_NUM-1:0]                ar_o;
    logic [CHAN_NUM-1:0]                   ar_ready_i;
    logic [CHAN_NUM-1:0]                   r_valid_i;
    rd_beat_t [CHAN_NUM-1:0]               r_i;
    logic [CHAN_NUM-1:0]                   r_ready_o;
    logic [ENGINE_NUM-1:0][DISPATCH_W-1:0] dispatch_data_o;
    logic [ENGINE_NUM-1:0]                 dispatch_wr_en_o;
    logic [ENGINE_NUM-1:0]                 dispatch_almost_full_i;
    logic                                  done_o;

    ////////////////////////////////////////////////////////////
    // model state
    ////////////////////////////////////////////////////////////

    logic [31:0]           lfsr_q;
    logic [HBM_DATA_W-1:0] model_q [CHAN_NUM][$];  // beats taken, per channel
    int                    pend_beats [CHAN_NUM];  // beats owed by memory
    int                    beat_pos [CHAN_NUM];    // position in burst
    logic                  beat_live [CHAN_NUM];   // beat shown, not yet taken
    int                    req_cnt [CHAN_NUM];
    int                    disp_cnt [ENGINE_NUM];
    int                    af_run [ENGINE_NUM];    // cycles almost-full held high
    hbm_addr_t             exp_base;
    hbm_addr_t             exp_stride;
    int                    exp_bursts;
    int                    done_cnt;
    int                    err_cnt;
    int                    pass_tests;
    int                    fail_tests;
    logic                  idle_watch;
    logic                  aborted;

    hbm_read_top #(
        .ENGINE_NUM (ENGINE_NUM)
    ) i_dut (
        .hbm_clk                (hbm_clk),
        .hbm_rstn               (hbm_rstn),
        .start_i                (start_i),
        .base_addr_i            (base_addr_i),
        .stride_i               (stride_i),
        .burst_count_i          (burst_count_i),
        .ar_valid_o             (ar_valid_o),
        .ar_o                   (ar_o),
        .ar_ready_i             (ar_ready_i),
        .r_valid_i              (r_valid_i),
        .r_i                    (r_i),
        .r_ready_o              (r_ready_o),
        .dispatch_data_o        (dispatch_data_o),
        .dispatch_wr_en_o       (dispatch_wr_en_o),
        .dispatch_almost_full_i (dispatch_almost_full_i),
        .done_o                 (done_o)
    );

    always #2 hbm_clk = ~hbm_clk;  // 4 ns period

    ////////////////////////////////////////////////////////////
    // random source
    ////////////////////////////////////////////////////////////

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic rand_bit();
        lfsr_q = lfsr_step(lfsr_q);
        return lfsr_q[0];
    endfunction

    function automatic logic [HBM_DATA_W-1:0] take_bits(input int n);
        logic [HBM_DATA_W-1:0] w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            w = {w[HBM_DATA_W-2:0], rand_bit()};  // one step per bit
        end
        return w;
    endfunction

    task automatic check_val(input string name, input logic [DISPATCH_W-1:0] exp_v,
                             input logic [DISPATCH_W-1:0] got_v);
        assert (got_v === exp_v) else begin
            $display("ERR t=%0t %s exp=%0h got=%0h", $time, name, exp_v, got_v);
            err_cnt++;
        end
    endtask

    task automatic check_true(input string what, input logic cond);
        assert (cond === 1'b1) else begin
            $display("FAIL t=%0t %s", $time, what);
            err_cnt++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // sampling at falling edge, driving after rising edge
    ////////////////////////////////////////////////////////////

    task automatic sample_outputs();
        logic [DISPATCH_W-1:0] exp_word;
        hbm_addr_t             exp_addr;
        for (int e = 0; e < ENGINE_NUM; e++) begin
            af_run[e] = dispatch_almost_full_i[e] ? af_run[e] + 1 : 0;
            if (af_run[e] >= 4) begin  // third cycle after the rise on
                check_true($sformatf("dispatch_wr_en_o[%0d] high under almost-full", e),
                           !dispatch_wr_en_o[e]);
            end
            if (dispatch_wr_en_o[e]) begin
                disp_cnt[e]++;
                if (model_q[2*e].size() > 0 && model_q[2*e+1].size() > 0) begin
                    exp_word = {model_q[2*e+1].pop_front(), model_q[2*e].pop_front()};
                    check_val($sformatf("dispatch_data_o[%0d]", e), exp_word,
                              dispatch_data_o[e]);
                end else begin
                    check_true($sformatf("dispatch word on engine %0d with no beats", e), 0);
                end
            end
        end
        for (int c = 0; c < CHAN_NUM; c++) begin
            if (ar_valid_o[c] && ar_ready_i[c]) begin  // request taken at next edge
                check_true($sformatf("extra read request on channel %0d", c),
                           req_cnt[c] < exp_bursts);
                exp_addr = exp_base + exp_stride * hbm_addr_t'(req_cnt[c]);
                check_val($sformatf("ar_o[%0d].addr", c), exp_addr, ar_o[c].addr);
                check_val($sformatf("ar_o[%0d].len", c), BURST_BEATS - 1, ar_o[c].len);
                req_cnt[c]++;
                pend_beats[c] += BURST_BEATS;
            end
            if (r_valid_i[c] && r_ready_o[c]) begin
                model_q[c].push_back(r_i[c].data);
                beat_live[c] = 1'b0;
            end
        end
        if (done_o) done_cnt++;
        if (idle_watch) begin
            check_true("ar_valid_o high with no start", ar_valid_o == '0);
            check_true("dispatch_wr_en_o high with no start", dispatch_wr_en_o == '0);
            check_true("done_o high with no start", !done_o);
        end
    endtask

    task automatic drive_inputs();
        start_i = 1'b0;  // start is a single-cycle pulse
        for (int c = 0; c < CHAN_NUM; c++) begin
            ar_ready_i[c] = rand_bit();
            if (!beat_live[c] && pend_beats[c] > 0 && rand_bit()) begin
                beat_live[c]  = 1'b1;
                pend_beats[c] = pend_beats[c] - 1;
                r_i[c].data   = take_bits(HBM_DATA_W);
                r_i[c].last   = (beat_pos[c] == BURST_BEATS - 1);
                beat_pos[c]   = (beat_pos[c] + 1) % BURST_BEATS;
            end
            r_valid_i[c] = beat_live[c];  // held until taken
        end
        for (int e = 0; e < ENGINE_NUM; e++) begin
            if (take_bits(3) == '0) begin  // long random stretches
                dispatch_almost_full_i[e] = ~dispatch_almost_full_i[e];
            end
        end
    endtask

    task automatic step_cycle();
        @(negedge hbm_clk);
        sample_outputs();
        @(posedge hbm_clk);
        #1;
        drive_inputs();
    endtask

    task automatic close_test(input string name, input int err_before);
        if (err_cnt == err_before) begin
            pass_tests++;
            $display("test %s: ok", name);
        end else begin
            fail_tests++;
            $display("test %s: %0d errors", name, err_cnt - err_before);
        end
    endtask

    task automatic run_test(input string name, input hbm_addr_t base, input hbm_addr_t stride,
                            input int count);
        int err_before;
        int cycles;
        err_before = err_cnt;
        exp_base   = base;
        exp_stride = stride;
        exp_bursts = count;
        done_cnt   = 0;
        for (int c = 0; c < CHAN_NUM; c++) req_cnt[c] = 0;
        for (int e = 0; e < ENGINE_NUM; e++) disp_cnt[e] = 0;
        base_addr_i   = base;
        stride_i      = stride;
        burst_count_i = BURST_CNT_W'(count);
        start_i       = 1'b1;
        cycles        = 0;
        while (done_cnt == 0 && cycles < RUN_TIMEOUT) begin
            step_cycle();
            cycles++;
        end
        if (done_cnt == 0) begin
            $display("timeout: run %s never pulsed done_o", name);
            err_cnt++;
            aborted = 1'b1;
        end else begin
            for (int e = 0; e < ENGINE_NUM; e++) begin  // done must follow the last word
                check_val($sformatf("dispatch count engine %0d at done", e),
                          count * BURST_BEATS, disp_cnt[e]);
            end
            repeat (QUIET_CYCLES) step_cycle();
            check_val("done_o pulse count", 1, done_cnt);
            for (int c = 0; c < CHAN_NUM; c++) begin
                check_val($sformatf("request count channel %0d", c), count, req_cnt[c]);
                check_true($sformatf("beats left over on channel %0d", c),
                           model_q[c].size() == 0 && pend_beats[c] == 0);
            end
            for (int e = 0; e < ENGINE_NUM; e++) begin
                check_val($sformatf("dispatch count engine %0d", e),
                          count * BURST_BEATS, disp_cnt[e]);
            end
        end
        close_test(name, err_before);
    endtask

    ////////////////////////////////////////////////////////////
    // sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int err_before;
        hbm_clk                = 1'b0;
        hbm_rstn               = 1'b0;
        start_i                = 1'b0;
        base_addr_i            = '0;
        stride_i               = '0;
        burst_count_i          = '0;
        ar_ready_i             = '0;
        r_valid_i              = '0;
        r_i                    = '0;
        dispatch_almost_full_i = '0;
        lfsr_q                 = 32'h93d3_2db7;
        err_cnt                = 0;
        pass_tests             = 0;
        fail_tests             = 0;
        aborted                = 1'b0;
        idle_watch             = 1'b0;
        exp_bursts             = 0;
        done_cnt               = 0;
        for (int c = 0; c < CHAN_NUM; c++) begin
            pend_beats[c] = 0;
            beat_pos[c]   = 0;
            beat_live[c]  = 1'b0;
            req_cnt[c]    = 0;
        end
        for (int e = 0; e < ENGINE_NUM; e++) begin
            disp_cnt[e] = 0;
            af_run[e]   = 0;
        end
        repeat (4) @(posedge hbm_clk);
        #1;
        hbm_rstn = 1'b1;

        // quiet after reset, nothing moves without a start
        err_before = err_cnt;
        idle_watch = 1'b1;
        repeat (QUIET_CYCLES) step_cycle();
        idle_watch = 1'b0;
        close_test("idle", err_before);

        // six bursts per channel, more than a fifo holds
        run_test("run_six_bursts", hbm_addr_t'(take_bits(26)) << 5, 33'h0_0000_2040, 6);
        if (!aborted) begin
            run_test("run_zero_bursts", hbm_addr_t'(take_bits(28)) << 5, 33'h0_0001_0000, 0);
        end

        $display("tests: %0d passed, %0d failed, %0d errors", pass_tests, fail_tests, err_cnt);
        if (err_cnt == 0 && fail_tests == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
logic/hbm_pkg.sv
logic/hbm_run_ctrl.sv
logic/hbm_burst_counter.sv
logic/hbm_chan_fifo.sv
logic/hbm_lane_pair.sv
logic/hbm_read_top.sv
verification/tb_hbm_read.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the hbm read side testbench with verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module tb_hbm_read -Mdir obj_dir > build.log 2>&1 \
    || { echo "verilator build failed, see build.log"; exit 1; }

./obj_dir/Vtb_hbm_read 2>&1 | tee sim.log

grep -qx "ALL TESTS PASSED" sim.log \
    && echo "result: pass" \
    || { echo "result: fail, see sim.log"; exit 1; }
